//--- Makefile
OBJ = obj_dir
LOG = sim.log

all: run

run:
	verilator --binary --timing --assert --timescale 1ns/10ps -f filelist.f \
		--top-module lcd_tb -Mdir $(OBJ) -o lcd_sim
	-$(OBJ)/lcd_sim | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/10ps -f filelist.f \
		--top-module lcd_tb

clean:
	rm -rf $(OBJ) $(LOG)

.PHONY: all run lint clean

//--- filelist.f
rtl/wb_pkg.sv
rtl/lcd_pkg.sv
rtl/wb_arbiter.sv
rtl/frame_ram.sv
rtl/pixel_fetch.sv
rtl/lcd_iface.sv
rtl/lcd_subsys_top.sv
verification/lcd_sva.sv
verification/lcd_tb.sv

//--- rtl/frame_ram.sv
/*
 Framebuffer memory behind a Wishbone classic slave port.
 Single-cycle registered ack, read data valid together with ack.
*/
`timescale 1ns/10ps

module frame_ram (
	input  logic            clk,
	input  logic            nrst,
	input  wb_pkg::wb_req_t req,
	output wb_pkg::wb_rsp_t rsp
);

	logic [wb_pkg::WB_DW-1:0] mem [lcd_pkg::RAM_WORDS];
	logic [wb_pkg::WB_DW-1:0] rdat;
	logic                     ack;
	logic                     access;

	// new strobe, not the one being acked right now
	assign access = req.cyc && req.stb && !ack;

	always_ff @(posedge clk) begin
		if (!nrst)
			ack <= 1'b0;
		else
			ack <= access;
	end

	always_ff @(posedge clk) begin
		if (access) begin
			if (req.we)
				mem[req.adr] <= req.dat;
			rdat <= mem[req.adr]; // old data on a write
		end
	end

	assign rsp = '{ack: ack, dat: rdat};

endmodule

//--- rtl/lcd_iface.sv
/*
 Host register slave for the LCD plus the 8080-style transfer sequencer.
 Pixels from the fetcher go first, host command and data accesses fill the gaps.
*/
`timescale 1ns/10ps

module lcd_iface (
	input  logic                        clk,
	input  logic                        nrst,
	input  wb_pkg::wb_req_t             reg_req,
	output wb_pkg::wb_rsp_t             reg_rsp,
	input  lcd_pkg::pixel_t             pixel,
	input  logic                        pixel_valid,
	output logic                        pixel_ready,
	output logic                        render_en,
	output lcd_pkg::lcd_out_t           lcd,
	input  logic [lcd_pkg::LCD_DW-1:0]  lcd_db_in,
	input  logic                        lcd_id,
	input  logic                        lcd_fmark
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_LATCH,   // rs and data settle
		S_STB1,
		S_STB2,
		S_RELEASE  // strobe back high
	} state_t;

	state_t                     state;
	logic [lcd_pkg::CTL_W-1:0]  ctl;
	logic [lcd_pkg::LCD_DW-1:0] startcmd;
	logic [wb_pkg::WB_DW-1:0]   rdata;  // read buffer for the host
	logic [wb_pkg::WB_DW-1:0]   local_rdata;
	logic [lcd_pkg::LCD_DW-1:0] db_out;
	logic                       db_oe;
	logic                       rd_n;
	logic                       wr_n;
	logic                       rs;
	logic                       ack;
	logic                       is_write;
	logic                       is_host;
	logic                       sent_start; // startcmd already out for this field
	logic [2:0]                 radr;
	logic                       host_xfer;
	logic                       local_hit;
	logic                       pix_start;
	logic                       host_go;
	logic                       rd_sample;

	assign radr      = reg_req.adr[2:0];
	assign host_xfer = reg_req.cyc && reg_req.stb &&
		(radr == lcd_pkg::REG_CMD || radr == lcd_pkg::REG_DATA);
	assign local_hit = reg_req.cyc && reg_req.stb && !host_xfer && !ack;

	// field start pixel waits for its startcmd transfer
	assign pix_start   = state == S_IDLE && pixel_valid && pixel.field_start && !sent_start;
	assign pixel_ready = state == S_IDLE && pixel_valid && !pix_start;
	assign host_go     = state == S_IDLE && !pixel_valid && host_xfer;
	assign rd_sample   = state == S_STB2 && !is_write;

	always_comb begin
		case (radr)
			lcd_pkg::REG_CTL:      local_rdata = wb_pkg::WB_DW'(ctl);
			lcd_pkg::REG_STATUS:   local_rdata = {30'd0, lcd_id, lcd_fmark};
			lcd_pkg::REG_STARTCMD: local_rdata = wb_pkg::WB_DW'(startcmd);
			default:               local_rdata = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!nrst) begin
			state      <= S_IDLE;
			ctl        <= lcd_pkg::CTL_RESET_VAL;
			startcmd   <= lcd_pkg::STARTCMD_RESET_VAL;
			ack        <= 1'b0;
			wr_n       <= 1'b1;
			rd_n       <= 1'b1;
			db_oe      <= 1'b0;
			rs         <= 1'b0;
			is_write   <= 1'b0;
			is_host    <= 1'b0;
			sent_start <= 1'b0;
		end else begin
			ack <= local_hit; // one-cycle ack for local registers
			if (local_hit && reg_req.we) begin
				if (radr == lcd_pkg::REG_CTL)
					ctl <= reg_req.dat[lcd_pkg::CTL_W-1:0];
				if (radr == lcd_pkg::REG_STARTCMD)
					startcmd <= reg_req.dat[lcd_pkg::LCD_DW-1:0];
			end

			case (state)
				S_IDLE: begin
					if (pix_start || pixel_ready) begin
						rs         <= pixel_ready;
						is_write   <= 1'b1;
						is_host    <= 1'b0;
						db_oe      <= 1'b1;
						sent_start <= pix_start;
						state      <= S_LATCH;
					end else if (host_go) begin
						rs       <= radr[0]; // CMD at 0, DATA at 1
						is_write <= reg_req.we;
						is_host  <= 1'b1;
						db_oe    <= reg_req.we;
						state    <= S_LATCH;
					end
				end
				S_LATCH: begin
					wr_n  <= ~is_write;
					rd_n  <= is_write;
					state <= S_STB1;
				end
				S_STB1: state <= S_STB2;
				S_STB2: begin
					wr_n  <= 1'b1;
					rd_n  <= 1'b1;
					if (is_host)
						ack <= 1'b1;
					state <= S_RELEASE;
				end
				S_RELEASE: begin
					db_oe <= 1'b0;
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pix_start)
			db_out <= startcmd;
		else if (pixel_ready)
			db_out <= {pixel.red[7:2], pixel.green[7:2], pixel.blue[7:2]}; // 6:6:6
		else if (host_go)
			db_out <= reg_req.dat[lcd_pkg::LCD_DW-1:0];

		if (local_hit)
			rdata <= local_rdata;
		else if (rd_sample)
			rdata <= wb_pkg::WB_DW'(lcd_db_in); // sampled while rd_n still low
	end

	assign reg_rsp   = '{ack: ack, dat: rdata};
	assign render_en = ctl[lcd_pkg::CTL_RENDER];

	assign lcd = '{
		db_out: db_out,
		db_oe:  db_oe,
		rd_n:   rd_n,
		wr_n:   wr_n,
		rs:     rs,
		cs:     ctl[lcd_pkg::CTL_CS],
		rst_n:  ~ctl[lcd_pkg::CTL_RESET],
		blen:   ctl[lcd_pkg::CTL_BLEN]
	};

endmodule

//--- rtl/lcd_pkg.sv
/*
 LCD side definitions: pixel and panel bus types, host register map,
 control bits and frame geometry
*/
package lcd_pkg;

	localparam int LCD_DW = 18; // 6:6:6 parallel bus
	localparam int CTL_W  = 4;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
		logic       field_start; // first pixel of a frame
	} pixel_t;

	typedef struct packed {
		logic [LCD_DW-1:0] db_out;
		logic              db_oe;
		logic              rd_n;
		logic              wr_n;
		logic              rs;    // low for command, high for data
		logic              cs;
		logic              rst_n;
		logic              blen;  // backlight enable
	} lcd_out_t;

	// host register word offsets
	localparam logic [2:0] REG_CMD      = 3'd0;
	localparam logic [2:0] REG_DATA     = 3'd1;
	localparam logic [2:0] REG_CTL      = 3'd2;
	localparam logic [2:0] REG_STATUS   = 3'd3;
	localparam logic [2:0] REG_STARTCMD = 3'd4;

	// control register bits
	localparam int CTL_BLEN   = 0;
	localparam int CTL_RESET  = 1; // set holds the panel in reset
	localparam int CTL_CS     = 2;
	localparam int CTL_RENDER = 3;

	localparam logic [CTL_W-1:0]  CTL_RESET_VAL      = 4'h6;
	localparam logic [LCD_DW-1:0] STARTCMD_RESET_VAL = 18'h2c; // memory write

	localparam int FRAME_PIXELS = 16;
	localparam int RAM_WORDS    = 1024;

endpackage

//--- rtl/lcd_subsys_top.sv
/*
 LCD subsystem top: host register and memory ports, shared frame RAM,
 pixel fetcher and the LCD interface
*/
`timescale 1ns/10ps

module lcd_subsys_top (
	input  logic                       clk,
	input  logic                       nrst,
	input  wb_pkg::wb_req_t            host_reg_req,
	output wb_pkg::wb_rsp_t            host_reg_rsp,
	input  wb_pkg::wb_req_t            host_mem_req,
	output wb_pkg::wb_rsp_t            host_mem_rsp,
	output lcd_pkg::lcd_out_t          lcd,
	input  logic [lcd_pkg::LCD_DW-1:0] lcd_db_in,
	input  logic                       lcd_id,
	input  logic                       lcd_fmark
);

	wb_pkg::wb_req_t fetch_req;
	wb_pkg::wb_rsp_t fetch_rsp;
	wb_pkg::wb_req_t ram_req;
	wb_pkg::wb_rsp_t ram_rsp;
	lcd_pkg::pixel_t pixel;
	logic            pixel_valid;
	logic            pixel_ready;
	logic            render_en;

	wb_arbiter u_arb (
		.clk(clk), .nrst(nrst),
		.m0_req(host_mem_req), .m0_rsp(host_mem_rsp),
		.m1_req(fetch_req), .m1_rsp(fetch_rsp),
		.s_req(ram_req), .s_rsp(ram_rsp)
	);

	frame_ram u_ram (.clk(clk), .nrst(nrst), .req(ram_req), .rsp(ram_rsp));

	pixel_fetch u_fetch (
		.clk(clk), .nrst(nrst), .render_en(render_en),
		.wb_req(fetch_req), .wb_rsp(fetch_rsp),
		.pixel(pixel), .pixel_valid(pixel_valid), .pixel_ready(pixel_ready)
	);

	lcd_iface u_lcd (
		.clk(clk), .nrst(nrst),
		.reg_req(host_reg_req), .reg_rsp(host_reg_rsp),
		.pixel(pixel), .pixel_valid(pixel_valid), .pixel_ready(pixel_ready),
		.render_en(render_en), .lcd(lcd),
		.lcd_db_in(lcd_db_in), .lcd_id(lcd_id), .lcd_fmark(lcd_fmark)
	);

endmodule

//--- rtl/pixel_fetch.sv
/*
 Reads the framebuffer word by word while render mode is on and offers
 each pixel on a valid/ready handshake, flagging word 0 as field start
*/
`timescale 1ns/10ps

module pixel_fetch (
	input  logic            clk,
	input  logic            nrst,
	input  logic            render_en,
	output wb_pkg::wb_req_t wb_req,
	input  wb_pkg::wb_rsp_t wb_rsp,
	output lcd_pkg::pixel_t pixel,
	output logic            pixel_valid,
	input  logic            pixel_ready
);

	localparam int IDX_W = $clog2(lcd_pkg::FRAME_PIXELS);

	typedef enum logic [1:0] {
		S_IDLE,
		S_READ,
		S_OFFER
	} state_t;

	state_t          state;
	logic [IDX_W-1:0] idx;

	always_ff @(posedge clk) begin
		if (!nrst) begin
			state <= S_IDLE;
			idx   <= '0;
		end else begin
			case (state)
				S_IDLE: if (render_en) begin
					idx   <= '0; // every start begins a new frame
					state <= S_READ;
				end
				S_READ: if (wb_rsp.ack)
					state <= S_OFFER;
				S_OFFER: if (pixel_ready) begin
					idx   <= (idx == IDX_W'(lcd_pkg::FRAME_PIXELS - 1)) ? '0 : idx + 1'b1;
					state <= render_en ? S_READ : S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// word layout is 0x00RRGGBB
	always_ff @(posedge clk) begin
		if (state == S_READ && wb_rsp.ack) begin
			pixel.red         <= wb_rsp.dat[23:16];
			pixel.green       <= wb_rsp.dat[15:8];
			pixel.blue        <= wb_rsp.dat[7:0];
			pixel.field_start <= (idx == '0);
		end
	end

	assign pixel_valid = (state == S_OFFER);

	always_comb begin
		wb_req     = '0; // read only
		wb_req.cyc = (state == S_READ);
		wb_req.stb = (state == S_READ);
		wb_req.adr = wb_pkg::WB_AW'(idx);
	end

endmodule

//--- rtl/wb_arbiter.sv
/*
 Round-robin arbiter letting two Wishbone masters share one slave.
 Port 0 is the host memory port, port 1 the pixel fetcher.
*/
`timescale 1ns/10ps

module wb_arbiter (
	input  logic            clk,
	input  logic            nrst,
	input  wb_pkg::wb_req_t m0_req,
	output wb_pkg::wb_rsp_t m0_rsp,
	input  wb_pkg::wb_req_t m1_req,
	output wb_pkg::wb_rsp_t m1_rsp,
	output wb_pkg::wb_req_t s_req,
	input  wb_pkg::wb_rsp_t s_rsp
);

	logic busy;  // a master owned the bus last cycle
	logic gnt;   // that owner
	logic last;  // master that got the most recent ack
	logic hold;
	logic sel;

	// owner keeps the bus while its cycle is open
	assign hold = busy && (gnt ? m1_req.cyc : m0_req.cyc);

	always_comb begin
		if (hold)
			sel = gnt;
		else if (m0_req.cyc && m1_req.cyc)
			sel = ~last; // both asking, take turns
		else
			sel = m1_req.cyc;
	end

	assign s_req = sel ? m1_req : m0_req;

	// the master not granted sees no ack and keeps waiting
	always_comb begin
		m0_rsp     = s_rsp;
		m0_rsp.ack = s_rsp.ack && !sel;
		m1_rsp     = s_rsp;
		m1_rsp.ack = s_rsp.ack && sel;
	end

	always_ff @(posedge clk) begin
		if (!nrst) begin
			busy <= 1'b0;
			gnt  <= 1'b0;
			last <= 1'b1; // host wins the first tie
		end else begin
			busy <= s_req.cyc;
			gnt  <= sel;
			if (s_rsp.ack)
				last <= sel;
		end
	end

endmodule

//--- rtl/wb_pkg.sv
/*
 Wishbone classic bus types shared by the host ports, the arbiter,
 the frame RAM and the pixel fetcher
*/
package wb_pkg;

	localparam int WB_AW = 10; // word address
	localparam int WB_DW = 32;

	// master to slave
	typedef struct packed {
		logic             cyc;
		logic             stb;
		logic             we;
		logic [WB_AW-1:0] adr;
		logic [WB_DW-1:0] dat;
	} wb_req_t;

	// slave to master
	typedef struct packed {
		logic             ack;
		logic [WB_DW-1:0] dat;
	} wb_rsp_t;

endpackage

//--- verification/lcd_sva.sv
/*
 Assertions bound into the LCD interface: strobe exclusivity, data bus
 driven during writes and single-cycle register acks
*/
`timescale 1ns/10ps

module lcd_sva (
	input logic              clk,
	input logic              nrst,
	input wb_pkg::wb_rsp_t   reg_rsp,
	input lcd_pkg::lcd_out_t lcd
);

	a_strobes: assert property (@(posedge clk) disable iff (!nrst)
		!(!lcd.wr_n && !lcd.rd_n))
		else $error("wr_n and rd_n low together");

	// classic slave, ack one cycle only
	a_ack: assert property (@(posedge clk) disable iff (!nrst)
		reg_rsp.ack |=> !reg_rsp.ack)
		else $error("register ack high for two cycles");

	a_oe: assert property (@(posedge clk) disable iff (!nrst)
		!lcd.wr_n |-> lcd.db_oe)
		else $error("data bus not driven during a write strobe");

endmodule

bind lcd_iface lcd_sva u_sva (.clk(clk), .nrst(nrst), .reg_rsp(reg_rsp), .lcd(lcd));

//--- verification/lcd_tb.sv
/*
 Directed testbench for the LCD subsystem: drives the host register and
 memory ports, models the panel write strobes and checks render and sharing
*/
`timescale 1ns/10ps

module lcd_tb;

	localparam int MAX_CYCLES = 20000; // two frames and the host traffic fit many times over
	localparam int ACK_WAIT   = 200;
	localparam int NPIX       = lcd_pkg::FRAME_PIXELS;
	localparam logic PORT_REG = 1'b0;
	localparam logic PORT_MEM = 1'b1;
	localparam logic [9:0] A_CMD      = 10'(lcd_pkg::REG_CMD);
	localparam logic [9:0] A_DATA     = 10'(lcd_pkg::REG_DATA);
	localparam logic [9:0] A_CTL      = 10'(lcd_pkg::REG_CTL);
	localparam logic [9:0] A_STATUS   = 10'(lcd_pkg::REG_STATUS);
	localparam logic [9:0] A_STARTCMD = 10'(lcd_pkg::REG_STARTCMD);
	localparam logic [31:0] STARTCMD_VAL = 32'habcd_1234;
	localparam logic [31:0] SHARE_DATA   = 32'h0002_c3a5;

	logic              clk;
	logic              nrst;
	wb_pkg::wb_req_t   host_reg_req;
	wb_pkg::wb_rsp_t   host_reg_rsp;
	wb_pkg::wb_req_t   host_mem_req;
	wb_pkg::wb_rsp_t   host_mem_rsp;
	lcd_pkg::lcd_out_t lcd;
	logic [17:0]       lcd_db_in;
	logic              lcd_id;
	logic              lcd_fmark;

	logic              wr_n_mon;
	logic [18:0]       panel_q[$]; // {rs, db_out} per write strobe
	logic [31:0]       frame[NPIX];
	logic [17:0]       start_cmd;
	logic              data_done;
	int                seed;
	int                cycles = 0;

	lcd_subsys_top UUT (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// panel model records one entry per rising wr_n
	assign wr_n_mon = lcd.wr_n;
	always @(posedge wr_n_mon)
		if (nrst)
			panel_q.push_back({lcd.rs, lcd.db_out});

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES)
			fail("run did not finish within the cycle limit");
	end

	task automatic fail(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			fail($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	// render stream entry j, entry 0 is the start command and 1 to 16 the frame in order
	function automatic logic [18:0] render_entry(input int j);
		logic [31:0] w;
		if (j % (NPIX + 1) == 0)
			return {1'b0, start_cmd};
		w = frame[j % (NPIX + 1) - 1];
		return {1'b1, w[23:18], w[15:10], w[7:2]};
	endfunction

	// one classic cycle held until ack is seen before a rising edge
	task automatic bus_access(input logic port, input logic we, input logic [9:0] adr,
			input logic [31:0] wdat, output logic [31:0] rdat);
		wb_pkg::wb_req_t req;
		int              n;
		req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		n = 0;
		if (port == PORT_MEM)
			host_mem_req = req;
		else
			host_reg_req = req;
		do begin
			@(negedge clk);
			n++;
			if (n > ACK_WAIT)
				fail("host bus access got no ack");
		end while (!(port == PORT_MEM ? host_mem_rsp.ack : host_reg_rsp.ack));
		rdat = (port == PORT_MEM) ? host_mem_rsp.dat : host_reg_rsp.dat;
		@(posedge clk);
		#2;
		if (port == PORT_MEM)
			host_mem_req = '0;
		else
			host_reg_req = '0;
	endtask

	task automatic wb_write(input logic port, input logic [9:0] adr, input logic [31:0] dat);
		logic [31:0] ignored;
		bus_access(port, 1'b1, adr, dat, ignored);
	endtask

	task automatic wb_read(input logic port, input logic [9:0] adr, output logic [31:0] dat);
		bus_access(port, 1'b0, adr, 32'd0, dat);
	endtask

	task automatic wait_entries(input int n);
		int t;
		t = 0;
		while (panel_q.size() < n) begin
			@(posedge clk);
			#2;
			t++;
			if (t > 2000)
				fail("panel did not receive the expected write strobes");
		end
	endtask

	task automatic reset_state;
		logic [31:0] d;
		wb_read(PORT_REG, A_CTL, d);
		check("ctl", d, 32'h6);
		check("rst_n", 32'(lcd.rst_n), 32'd0);
		check("cs", 32'(lcd.cs), 32'd1);
		check("wr_n", 32'(lcd.wr_n), 32'd1);
		check("rd_n", 32'(lcd.rd_n), 32'd1);
		check("db_oe", 32'(lcd.db_oe), 32'd0);
		wb_read(PORT_REG, A_STARTCMD, d);
		check("startcmd", d, 32'h2c);
	endtask

	task automatic register_access;
		logic [31:0] d;
		logic [31:0] vals[2];
		vals = '{32'hffff_fff2, 32'h1234_5675}; // render bit kept clear
		foreach (vals[i]) begin
			wb_write(PORT_REG, A_CTL, vals[i]);
			wb_read(PORT_REG, A_CTL, d);
			check("ctl", d, vals[i] & 32'hf);
			check("blen", 32'(lcd.blen), 32'(vals[i][0]));
			check("rst_n", 32'(lcd.rst_n), 32'(!vals[i][1]));
			check("cs", 32'(lcd.cs), 32'(vals[i][2]));
		end
		wb_write(PORT_REG, A_STARTCMD, STARTCMD_VAL);
		wb_read(PORT_REG, A_STARTCMD, d);
		check("startcmd", d, STARTCMD_VAL & 32'h3ffff);
		start_cmd = STARTCMD_VAL[17:0];
		lcd_id    = 1'b1;
		lcd_fmark = 1'b0;
		wb_read(PORT_REG, A_STATUS, d);
		check("status", d, 32'h2);
		lcd_id    = 1'b0;
		lcd_fmark = 1'b1;
		wb_read(PORT_REG, A_STATUS, d);
		check("status", d, 32'h1);
	endtask

	task automatic host_transfers;
		logic [31:0] cmd_w;
		logic [31:0] dat_w;
		cmd_w = 32'hdead_beef;
		dat_w = 32'h0001_5a5a;
		panel_q.delete();
		wb_write(PORT_REG, A_CMD, cmd_w);
		wb_write(PORT_REG, A_DATA, dat_w);
		check("panel writes", 32'(panel_q.size()), 32'd2);
		check("cmd on panel", 32'(panel_q[0]), 32'({1'b0, cmd_w[17:0]}));
		check("data on panel", 32'(panel_q[1]), 32'({1'b1, dat_w[17:0]}));
	endtask

	task automatic host_readback;
		logic [31:0] d;
		lcd_db_in = 18'h2_a5c3;
		wb_read(PORT_REG, A_CMD, d);
		check("cmd read", d, 32'h0002_a5c3);
		check("panel writes", 32'(panel_q.size()), 32'd2); // a read strobes rd_n only
	endtask

	task automatic render_frames;
		panel_q.delete();
		for (int i = 0; i < NPIX; i++) begin
			frame[i] = $random(seed);
			wb_write(PORT_MEM, 10'(i), frame[i]);
		end
		wb_write(PORT_REG, A_CTL, 32'hd); // render with cs high and backlight on
		wait_entries(NPIX + 2);
		check("frame start cmd", 32'(panel_q[0]), 32'(render_entry(0)));
		for (int i = 0; i < NPIX; i++)
			check($sformatf("pixel %0d", i), 32'(panel_q[i + 1]), 32'(render_entry(i + 1)));
		check("next frame start cmd", 32'(panel_q[NPIX + 1]), 32'(render_entry(NPIX + 1)));
	endtask

	// host memory traffic keeps the fetcher off the RAM so the host DATA write gets a gap
	task automatic bus_sharing;
		logic [31:0] d;
		int          at;
		int          k;
		int          ph;
		panel_q.delete();
		wait_entries(2);
		data_done = 1'b0;
		at = 0;
		k  = 0;
		ph = -1;
		fork
			begin
				wb_write(PORT_REG, A_DATA, SHARE_DATA);
				at = panel_q.size() - 1;
				data_done = 1'b1;
			end
			while (!data_done) begin
				wb_write(PORT_MEM, 10'd100, 32'h5000_0000 + k);
				wb_read(PORT_MEM, 10'd100, d);
				check("word 100", d, 32'h5000_0000 + k);
				k++;
			end
		join
		wait_entries(at + 2); // one render entry past the host write
		// where in the frame the recorded stream begins
		for (int p = 0; p <= NPIX; p++)
			if (ph < 0 && panel_q[0] == render_entry(p))
				ph = p;
		if (ph < 0)
			fail("panel stream during sharing does not follow the frame");
		for (int i = 1; i < at; i++)
			check($sformatf("render entry %0d", i), 32'(panel_q[i]),
				32'(render_entry(ph + i)));
		check("host data on panel", 32'(panel_q[at]), 32'({1'b1, SHARE_DATA[17:0]}));
		check("render after host data", 32'(panel_q[at + 1]), 32'(render_entry(ph + at)));
	endtask

	initial begin
		seed         = 75;
		nrst         = 1'b0;
		host_reg_req = '0;
		host_mem_req = '0;
		lcd_db_in    = '0;
		lcd_id       = 1'b0;
		lcd_fmark    = 1'b0;
		start_cmd    = 18'h2c;
		data_done    = 1'b0;
		repeat (5) @(posedge clk);
		#2;
		nrst = 1'b1;
		reset_state();
		register_access();
		host_transfers();
		host_readback();
		render_frames();
		bus_sharing();
		$display("=== PASS ===");
		$finish;
	end

endmodule
